/* ocl_hello.f */
+incdir+verilog
verilog/ocl_hello_pkg.sv
verilog/ocl_bus_slave.sv
verilog/hello_regs.sv
verilog/tick_counter.sv
verilog/ocl_hello_top.sv
bench/ocl_hello_tb.sv

/* Makefile */
# Verilator build for the register block testbench

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= ocl_hello_tb
FILELIST   ?= ocl_hello.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/ocl_hello_tb.sv */
//----------------------------------------------------------------------
// Register block testbench
// Bus writes and reads from a stimulus table, LED mask and counter checks
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_settings.svh"

module ocl_hello_tb;

  import ocl_hello_pkg::*;

  localparam int NUM_ROWS = 8;
  localparam int WAIT_MAX = 50;

  // One row: read address, example data, DIP value, expectations
  typedef struct packed {
    logic [`OCL_ADDR_W-1:0] addr;
    logic [`OCL_DATA_W-1:0] wdata;
    logic [`VLED_W-1:0]     dip;
    logic [`OCL_DATA_W-1:0] exp_rd;
    logic [`VLED_W-1:0]     exp_led;
  } stim_row_t;

  logic               clk_main_a0;
  logic               rst_main_n_sync;
  axil_req_t          bus_req;
  axil_rsp_t          bus_rsp;
  logic [`VLED_W-1:0] vdip;
  logic [`VLED_W-1:0] vled;
  cnt_ctrl_t          cnt_ctrl;
  cnt_status_t        cnt_status;

  stim_row_t              stim_table [NUM_ROWS];
  integer                 seed;
  logic [`OCL_DATA_W-1:0] rd_value;
  logic [`CNT_W-1:0]      held_cnt;
  logic [`CNT_W-1:0]      wm_list [4];

  initial begin
    clk_main_a0 = 1'b0;
    forever #50 clk_main_a0 = ~clk_main_a0;
  end

  ocl_hello_top ocl_hello_top_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus_req         (bus_req),
    .bus_rsp         (bus_rsp),
    .vdip            (vdip),
    .vled            (vled),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status)
  );

  //--------------------------------------------------------------------
  // Checking
  //--------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns %s: got 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "No response on %s", what);
  endtask

  // Register map rules: low half times the factor, LED shadow, or filler
  function automatic logic [31:0] expected_read(input logic [31:0] addr,
                                                input logic [31:0] wdata);
    logic [31:0] low;
    low = {16'h0000, wdata[15:0]};
    if (addr == `EXAMPLE_REG_ADDR) begin
      return low * 32'(`EXAMPLE_MULT);
    end else if (addr == `VLED_REG_ADDR) begin
      return low;
    end
    return `UNIMPL_REG_VALUE;
  endfunction

  task automatic set_row(input int idx, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [15:0] dip);
    stim_table[idx].addr    = addr;
    stim_table[idx].wdata   = wdata;
    stim_table[idx].dip     = dip;
    stim_table[idx].exp_rd  = expected_read(addr, wdata);
    stim_table[idx].exp_led = wdata[15:0] & dip;
  endtask

  task automatic build_table();
    logic [31:0] rnd_data;
    logic [31:0] rnd_dip;
    set_row(0, `EXAMPLE_REG_ADDR, 32'h0000_1234, 16'hFFFF);
    set_row(1, `VLED_REG_ADDR, 32'hABCD_5A5A, 16'h0F0F);
    set_row(2, 32'h0000_0508, 32'h1111_2222, 16'hFFFF);
    set_row(3, `EXAMPLE_REG_ADDR, 32'h0000_FFFF, 16'h00FF);
    // Random rows
    for (int i = 4; i < NUM_ROWS; i++) begin
      rnd_data = $random(seed);
      rnd_dip  = $random(seed);
      set_row(i, (i == 4) ? 32'h0000_0000 :
                 (i == 6) ? `VLED_REG_ADDR : `EXAMPLE_REG_ADDR,
              rnd_data, rnd_dip[15:0]);
    end
  endtask

  //--------------------------------------------------------------------
  // Bus tasks, all driving on the falling edge
  //--------------------------------------------------------------------
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    int waited;
    @(negedge clk_main_a0);
    bus_req.awvalid = 1'b1;
    bus_req.awaddr  = addr;
    waited = 0;
    while (!bus_rsp.awready) begin
      @(negedge clk_main_a0);
      waited++;
      if (waited > WAIT_MAX) timeout_fail("awready");
    end
    // Address taken on the edge just passed
    @(negedge clk_main_a0);
    bus_req.awvalid = 1'b0;
    bus_req.wvalid  = 1'b1;
    bus_req.wdata   = data;
    bus_req.bready  = 1'b1;
    // wready follows wvalid, so it is sampled at the edge itself
    waited = 0;
    @(posedge clk_main_a0);
    while (!bus_rsp.wready) begin
      waited++;
      if (waited > WAIT_MAX) timeout_fail("wready");
      @(posedge clk_main_a0);
    end
    @(negedge clk_main_a0);
    bus_req.wvalid = 1'b0;
    waited = 0;
    while (!bus_rsp.bvalid) begin
      @(negedge clk_main_a0);
      waited++;
      if (waited > WAIT_MAX) timeout_fail("bvalid");
    end
    check_value("bresp", 32'(bus_rsp.bresp), 32'd0);
    @(negedge clk_main_a0);
    bus_req.bready = 1'b0;
    check_value("bvalid", 32'(bus_rsp.bvalid), 32'd0);
  endtask

  // Read with rready held low for hold cycles after rvalid
  task automatic bus_read(input logic [31:0] addr, input int hold,
                          output logic [31:0] data);
    int          waited;
    int          latency;
    logic [31:0] first;
    @(negedge clk_main_a0);
    bus_req.arvalid = 1'b1;
    bus_req.araddr  = addr;
    bus_req.rready  = 1'b0;
    waited = 0;
    while (!bus_rsp.arready) begin
      @(negedge clk_main_a0);
      waited++;
      if (waited > WAIT_MAX) timeout_fail("arready");
    end
    // First cycle after the address handshake
    @(negedge clk_main_a0);
    bus_req.arvalid = 1'b0;
    latency = 1;
    while (!bus_rsp.rvalid) begin
      @(negedge clk_main_a0);
      latency++;
      if (latency > WAIT_MAX) timeout_fail("rvalid");
    end
    check_value("read latency", 32'(latency), 32'd2);
    check_value("rresp", 32'(bus_rsp.rresp), 32'd0);
    first = bus_rsp.rdata;
    // Stalled response keeps its data
    repeat (hold) begin
      @(negedge clk_main_a0);
      check_value("rvalid", 32'(bus_rsp.rvalid), 32'd1);
      check_value("rdata held", bus_rsp.rdata, first);
    end
    bus_req.rready = 1'b1;
    @(negedge clk_main_a0);
    bus_req.rready = 1'b0;
    check_value("rvalid", 32'(bus_rsp.rvalid), 32'd0);
    data = first;
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    seed            = 29;
    bus_req         = '0;
    vdip            = '0;
    cnt_ctrl        = '0;
    rst_main_n_sync = 1'b0;
    build_table();
    repeat (16) @(negedge clk_main_a0);

    // Idle levels with every flop in reset
    check_value("bvalid", 32'(bus_rsp.bvalid), 32'd0);
    check_value("rvalid", 32'(bus_rsp.rvalid), 32'd0);
    check_value("awready", 32'(bus_rsp.awready), 32'd1);
    check_value("arready", 32'(bus_rsp.arready), 32'd1);
    check_value("vled", 32'(vled), 32'd0);
    check_value("cnt_status", 32'(cnt_status), 32'd0);
    rst_main_n_sync = 1'b1;

    // Table rows: write example register, read the row address
    for (int i = 0; i < NUM_ROWS; i++) begin
      vdip = stim_table[i].dip;
      bus_write(`EXAMPLE_REG_ADDR, stim_table[i].wdata);
      bus_read(stim_table[i].addr, i % 3, rd_value);
      check_value("rdata", rd_value, stim_table[i].exp_rd);
      repeat (4) @(negedge clk_main_a0);
      check_value("vled", 32'(vled), 32'(stim_table[i].exp_led));
    end

    // Load with enable off
    cnt_ctrl            = '0;
    cnt_ctrl.load       = 1'b1;
    cnt_ctrl.load_value = 16'h1234;
    cnt_ctrl.watermark  = 16'h1000;
    repeat (2) @(negedge clk_main_a0);
    check_value("cnt", 32'(cnt_status.cnt), 32'h0000_1234);
    check_value("ge_watermark", 32'(cnt_status.ge_watermark), 32'd1);
    cnt_ctrl.load = 1'b0;

    // Clear
    cnt_ctrl.clear = 1'b1;
    repeat (2) @(negedge clk_main_a0);
    check_value("cnt", 32'(cnt_status.cnt), 32'd0);
    check_value("ge_watermark", 32'(cnt_status.ge_watermark), 32'd0);
    cnt_ctrl.clear = 1'b0;

    // Hold with enable off
    cnt_ctrl.load       = 1'b1;
    cnt_ctrl.load_value = 16'h00A5;
    @(negedge clk_main_a0);
    cnt_ctrl.load = 1'b0;
    @(negedge clk_main_a0);
    held_cnt = 16'h00A5;
    check_value("cnt", 32'(cnt_status.cnt), 32'(held_cnt));
    repeat (10) begin
      @(negedge clk_main_a0);
      check_value("cnt held", 32'(cnt_status.cnt), 32'(held_cnt));
    end

    // Watermark sweep around the held count
    wm_list[0] = 16'h00A6;
    wm_list[1] = 16'h00A5;
    wm_list[2] = 16'h0010;
    wm_list[3] = 16'hFFFF;
    for (int w = 0; w < 4; w++) begin
      cnt_ctrl.watermark = wm_list[w];
      repeat (2) @(negedge clk_main_a0);
      check_value("ge_watermark", 32'(cnt_status.ge_watermark),
                  32'(held_cnt >= wm_list[w]));
    end

    // One-shot run from just below all ones
    cnt_ctrl.oneshot    = 1'b1;
    cnt_ctrl.tick_value = '0;
    cnt_ctrl.load       = 1'b1;
    cnt_ctrl.load_value = 16'hFFFE;
    cnt_ctrl.enable     = 1'b1;
    cnt_ctrl.watermark  = 16'h8000;
    @(negedge clk_main_a0);
    cnt_ctrl.load = 1'b0;
    repeat (9) @(negedge clk_main_a0);
    check_value("cnt", 32'(cnt_status.cnt), 32'h0000_FFFF);
    check_value("tick", 32'(cnt_status.tick), 32'd1);
    check_value("tick_cnt", 32'(cnt_status.tick_cnt), 32'd0);
    check_value("ge_watermark", 32'(cnt_status.ge_watermark), 32'd1);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/ocl_hello_top.sv */
//----------------------------------------------------------------------
// Register block top level
// Bus slave feeding the registers, counter alongside
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_settings.svh"

module ocl_hello_top (
  input  logic                        clk_main_a0,
  input  logic                        rst_main_n_sync,
  input  ocl_hello_pkg::axil_req_t    bus_req,
  output ocl_hello_pkg::axil_rsp_t    bus_rsp,
  input  logic [`VLED_W-1:0]          vdip,
  output logic [`VLED_W-1:0]          vled,
  input  ocl_hello_pkg::cnt_ctrl_t    cnt_ctrl,
  output ocl_hello_pkg::cnt_status_t  cnt_status
);

  import ocl_hello_pkg::*;

  // Slave to register strobes and read return
  reg_wr_t                reg_wr;
  reg_rd_t                reg_rd;
  logic [`OCL_DATA_W-1:0] rd_data;

  ocl_bus_slave ocl_bus_slave_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .bus_req         (bus_req),
    .bus_rsp         (bus_rsp),
    .reg_wr          (reg_wr),
    .reg_rd          (reg_rd),
    .rd_data         (rd_data)
  );

  hello_regs hello_regs_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_wr          (reg_wr),
    .reg_rd          (reg_rd),
    .rd_data         (rd_data),
    .vdip            (vdip),
    .vled            (vled)
  );

  // Counter has no bus access, ports only
  tick_counter tick_counter_inst (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status)
  );

endmodule

`default_nettype wire

/* verilog/tick_counter.sv */
//----------------------------------------------------------------------
// Tick counter
// Prescaler plus 16-bit event counter with load, clear and one-shot
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_settings.svh"

module tick_counter (
  input  logic                        clk_main_a0,
  input  logic                        rst_main_n_sync,
  input  ocl_hello_pkg::cnt_ctrl_t    cnt_ctrl,
  output ocl_hello_pkg::cnt_status_t  cnt_status
);

  import ocl_hello_pkg::*;

  cnt_ctrl_t          ctrl_q;
  logic [`TICK_W-1:0] tick_cnt;
  logic [`TICK_W-1:0] tick_next;
  logic [`CNT_W-1:0]  cnt;
  logic [`CNT_W-1:0]  cnt_next;
  logic               wrap;
  logic               tick;
  logic               ge_watermark;

  // Control inputs flopped once
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= cnt_ctrl;
    end
  end

  //--------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------
  // Prescaler at or past its limit
  assign wrap = (tick_cnt >= ctrl_q.tick_value);

  always_comb begin
    // Prescaler ignores load
    if (ctrl_q.clear) begin
      tick_next = '0;
    end else if (!ctrl_q.enable) begin
      tick_next = tick_cnt;
    end else if (wrap) begin
      tick_next = '0;
    end else begin
      tick_next = tick_cnt + 1'b1;
    end

    // Clear, load, hold, then step
    if (ctrl_q.clear) begin
      cnt_next = '0;
    end else if (ctrl_q.load) begin
      cnt_next = ctrl_q.load_value;
    end else if (!ctrl_q.enable || !wrap) begin
      cnt_next = cnt;
    end else if (ctrl_q.oneshot && (cnt == '1)) begin
      // Sticks at all ones
      cnt_next = cnt;
    end else begin
      cnt_next = cnt + 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt     <= '0;
      cnt          <= '0;
      tick         <= 1'b0;
      ge_watermark <= 1'b0;
    end else begin
      tick_cnt     <= tick_next;
      cnt          <= cnt_next;
      // Flags from the new values
      tick         <= (tick_next >= ctrl_q.tick_value);
      ge_watermark <= (cnt_next >= ctrl_q.watermark);
    end
  end

  assign cnt_status = '{tick: tick, ge_watermark: ge_watermark,
                        tick_cnt: tick_cnt, cnt: cnt};

  // One-shot count must not roll over on its own
  a_oneshot_no_wrap: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      ctrl_q.oneshot && (cnt == '1) && !ctrl_q.clear && !ctrl_q.load |=> cnt != '0)
    else $error("One-shot counter wrapped to zero");

endmodule

`default_nettype wire

/* verilog/hello_regs.sv */
//----------------------------------------------------------------------
// Example and virtual LED registers
// Multiplied readback, LED shadow masked by synchronized DIP switches
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_settings.svh"

module hello_regs (
  input  logic                    clk_main_a0,
  input  logic                    rst_main_n_sync,
  input  ocl_hello_pkg::reg_wr_t  reg_wr,
  input  ocl_hello_pkg::reg_rd_t  reg_rd,
  output logic [`OCL_DATA_W-1:0]  rd_data,
  input  logic [`VLED_W-1:0]      vdip,
  output logic [`VLED_W-1:0]      vled
);

  logic [`OCL_DATA_W-1:0] example_q;
  logic [`OCL_DATA_W-1:0] example_mult;
  logic [`VLED_W-1:0]     vled_shadow;
  logic [`VLED_W-1:0]     vdip_q1;
  logic [`VLED_W-1:0]     vdip_q2;

  //--------------------------------------------------------------------
  // Example register
  //--------------------------------------------------------------------
  // Full word write, strobes ignored
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      example_q <= '0;
    end else if (reg_wr.wr && (reg_wr.addr == `EXAMPLE_REG_ADDR)) begin
      example_q <= reg_wr.data;
    end
  end

  // Readback is the low half times the factor
  assign example_mult = {{(`OCL_DATA_W-`VLED_W){1'b0}}, example_q[`VLED_W-1:0]}
                        * `OCL_DATA_W'(`EXAMPLE_MULT);

  //--------------------------------------------------------------------
  // Virtual LEDs
  //--------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_shadow <= '0;
      vdip_q1     <= '0;
      vdip_q2     <= '0;
      vled        <= '0;
    end else begin
      // Shadow trails the example register by one cycle
      vled_shadow <= example_q[`VLED_W-1:0];
      // Two stage DIP synchronizer
      vdip_q1     <= vdip;
      vdip_q2     <= vdip_q1;
      // Switch off LEDs whose DIP is clear
      vled        <= vled_shadow & vdip_q2;
    end
  end

  //--------------------------------------------------------------------
  // Read mux
  //--------------------------------------------------------------------
  // Loads only on a strobe, so data holds while the bus stalls
  always_ff @(posedge clk_main_a0) begin
    if (reg_rd.rd) begin
      case (reg_rd.addr)
        `EXAMPLE_REG_ADDR: rd_data <= example_mult;
        `VLED_REG_ADDR:    rd_data <= {{(`OCL_DATA_W-`VLED_W){1'b0}}, vled_shadow};
        default:           rd_data <= `UNIMPL_REG_VALUE;
      endcase
    end
  end

  // LED never lit where the DIP was off, through both sync stages
  a_vled_masked: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      (vled & ~$past(vdip, 3)) == '0)
    else $error("LED set with its DIP switch clear");

endmodule

`default_nettype wire

/* verilog/ocl_bus_slave.sv */
//----------------------------------------------------------------------
// Single-beat AXI-Lite slave
// Turns write and read transfers into register strobes
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_settings.svh"

module ocl_bus_slave (
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n_sync,
  input  ocl_hello_pkg::axil_req_t  bus_req,
  output ocl_hello_pkg::axil_rsp_t  bus_rsp,
  output ocl_hello_pkg::reg_wr_t    reg_wr,
  output ocl_hello_pkg::reg_rd_t    reg_rd,
  input  logic [`OCL_DATA_W-1:0]    rd_data
);

  import ocl_hello_pkg::*;

  wr_state_e              wr_state;
  logic [`OCL_ADDR_W-1:0] aw_addr_q;
  logic                   bvalid;
  logic                   wr_hs;

  rd_state_e              rd_state;
  logic [`OCL_ADDR_W-1:0] ar_addr_q;
  logic                   rvalid;

  //--------------------------------------------------------------------
  // Write channel
  //--------------------------------------------------------------------
  // Data accepted once per address, blocked while the response waits
  assign wr_hs = (wr_state == wr_active) && !bvalid && bus_req.wvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_state <= wr_idle;
      bvalid   <= 1'b0;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (bus_req.awvalid) begin
            wr_state <= wr_active;
          end
        end
        wr_active: begin
          // Back to idle only after the response is taken
          if (bvalid && bus_req.bready) begin
            wr_state <= wr_idle;
          end
        end
      endcase
      if (bvalid && bus_req.bready) begin
        bvalid <= 1'b0;
      end else if (wr_hs) begin
        bvalid <= 1'b1;
      end
    end
  end

  // Address capture on the AW handshake
  always_ff @(posedge clk_main_a0) begin
    if ((wr_state == wr_idle) && bus_req.awvalid) begin
      aw_addr_q <= bus_req.awaddr;
    end
  end

  //--------------------------------------------------------------------
  // Read channel
  //--------------------------------------------------------------------
  // Fixed latency: handshake, strobe, response
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (bus_req.arvalid) begin
            rd_state <= rd_addr;
          end
        end
        rd_addr: begin
          rd_state <= rd_resp;
        end
        rd_resp: begin
          if (bus_req.rready) begin
            rd_state <= rd_idle;
          end
        end
        default: begin
          rd_state <= rd_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if ((rd_state == rd_idle) && bus_req.arvalid) begin
      ar_addr_q <= bus_req.araddr;
    end
  end

  assign rvalid = (rd_state == rd_resp);

  // Register side strobes
  assign reg_wr = '{wr: wr_hs, addr: aw_addr_q, data: bus_req.wdata};
  assign reg_rd = '{rd: (rd_state == rd_addr), addr: ar_addr_q};

  // Responses always OKAY, rdata zero outside a valid beat
  always_comb begin
    bus_rsp         = '0;
    bus_rsp.awready = (wr_state == wr_idle);
    bus_rsp.wready  = wr_hs;
    bus_rsp.bvalid  = bvalid;
    bus_rsp.bresp   = 2'b00;
    bus_rsp.arready = (rd_state == rd_idle);
    bus_rsp.rvalid  = rvalid;
    bus_rsp.rdata   = rvalid ? rd_data : '0;
    bus_rsp.rresp   = 2'b00;
  end

  //--------------------------------------------------------------------
  // Protocol checks
  //--------------------------------------------------------------------
  property p_valid_hold(logic vld, logic rdy);
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      vld && !rdy |=> vld;
  endproperty

  a_bvalid_hold: assert property (p_valid_hold(bus_rsp.bvalid, bus_req.bready))
    else $error("bvalid dropped before bready");
  a_rvalid_hold: assert property (p_valid_hold(bus_rsp.rvalid, bus_req.rready))
    else $error("rvalid dropped before rready");

  // Register side must hold its read data while the host stalls
  a_rdata_stable: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      bus_rsp.rvalid && !bus_req.rready |=> $stable(bus_rsp.rdata))
    else $error("rdata changed while rvalid waited");

endmodule

`default_nettype wire

/* verilog/ocl_hello_pkg.sv */
//----------------------------------------------------------------------
// Register block types
// Bus channel bundles, register strobes, counter control and FSM states
//----------------------------------------------------------------------

`default_nettype none

`include "ocl_hello_settings.svh"

package ocl_hello_pkg;

  // Host to slave levels, all five channels
  typedef struct packed {
    logic                       awvalid;
    logic [`OCL_ADDR_W-1:0]     awaddr;
    logic                       wvalid;
    logic [`OCL_DATA_W-1:0]     wdata;
    logic [`OCL_DATA_W/8-1:0]   wstrb;
    logic                       bready;
    logic                       arvalid;
    logic [`OCL_ADDR_W-1:0]     araddr;
    logic                       rready;
  } axil_req_t;

  // Slave to host levels
  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    logic [1:0]                 bresp;
    logic                       arready;
    logic                       rvalid;
    logic [`OCL_DATA_W-1:0]     rdata;
    logic [1:0]                 rresp;
  } axil_rsp_t;

  // Register write strobe with its target
  typedef struct packed {
    logic                       wr;
    logic [`OCL_ADDR_W-1:0]     addr;
    logic [`OCL_DATA_W-1:0]     data;
  } reg_wr_t;

  // Register read strobe, data comes back a cycle later
  typedef struct packed {
    logic                       rd;
    logic [`OCL_ADDR_W-1:0]     addr;
  } reg_rd_t;

  // Counter controls
  typedef struct packed {
    logic                       enable;
    logic                       load;
    logic                       clear;
    logic                       oneshot;
    logic [`TICK_W-1:0]         tick_value;
    logic [`CNT_W-1:0]          load_value;
    logic [`CNT_W-1:0]          watermark;
  } cnt_ctrl_t;

  // Counter status, all registered
  typedef struct packed {
    logic                       tick;
    logic                       ge_watermark;
    logic [`TICK_W-1:0]         tick_cnt;
    logic [`CNT_W-1:0]          cnt;
  } cnt_status_t;

  // Write channel FSM
  typedef enum logic {
    wr_idle,
    wr_active
  } wr_state_e;

  // Read channel FSM
  typedef enum logic [1:0] {
    rd_idle,
    rd_addr,
    rd_resp
  } rd_state_e;

endpackage

`default_nettype wire

/* verilog/ocl_hello_settings.svh */
//----------------------------------------------------------------------
// Register block settings
// Bus widths, register map and readback constants
//----------------------------------------------------------------------

`ifndef OCL_HELLO_SETTINGS_SVH
`define OCL_HELLO_SETTINGS_SVH

// Host control bus widths
`define OCL_ADDR_W 32
`define OCL_DATA_W 32

// LED and DIP switch width
`define VLED_W 16

// Event counter and prescaler widths
`define CNT_W 16
`define TICK_W 8

//----------------------------------------------------------------------
// Register map
//----------------------------------------------------------------------
`define EXAMPLE_REG_ADDR 32'h0000_0500
`define VLED_REG_ADDR 32'h0000_0504

// Returned for any address outside the map
`define UNIMPL_REG_VALUE 32'hDEAD_DEAD

// Example register readback factor
`define EXAMPLE_MULT 5

`endif
